// ==== common/vstu_pkg.sv ====
// Vector store unit package with element width encoding, bus constants and byte count helper
package vstu_pkg;

  // Element width encoding
  // Byte length of an instruction is vl shifted left by this value
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2
  } ew_e;

  // Bytes per Wishbone data word
  localparam int unsigned BusBytes = 32'd4;

  // Width of one lane operand
  localparam int WordWidth = 32;

  // Total byte length of a store
  // vl elements of 1, 2 or 4 bytes each
  function automatic logic [31:0] insn_bytes(
    input logic [31:0] vl,
    input ew_e         ew
  );
    logic [31:0] bytes;
    bytes = vl << ew;
    return bytes;
  endfunction

endpackage

// ==== store/vinsn_queue.sv ====
// Store instruction queue with accept, issue and commit phases and in-order completion
`timescale 1ns/1ps

module vinsn_queue #(
  parameter int unsigned QueueDepth = 4,
  parameter int unsigned IdWidth    = 3,
  parameter int unsigned VlWidth    = 8,
  parameter int unsigned AddrWidth  = 16
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Sequencer side
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  logic [IdWidth-1:0]   req_id_i,
  input  logic [AddrWidth-1:0] req_addr_i,
  input  logic [VlWidth-1:0]   req_vl_i,
  input  vstu_pkg::ew_e        req_ew_i,
  // Beat generator side
  output logic                 issue_valid_o,
  output logic [AddrWidth-1:0] issue_addr_o,
  output logic [VlWidth-1:0]   issue_vl_o,
  output vstu_pkg::ew_e        issue_ew_o,
  input  logic                 issue_done_i,
  // Master side, last ack of an instruction
  input  logic                 commit_i,
  // Completion report
  output logic                 done_valid_o,
  output logic [IdWidth-1:0]   done_id_o,
  output logic                 store_pending_o
);

  localparam int PtrWidth = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int CntWidth = $clog2(QueueDepth + 1);
  localparam int NumIds   = 2 ** IdWidth;

  // Entry payload
  logic [IdWidth-1:0]   id_q   [QueueDepth];
  logic [AddrWidth-1:0] addr_q [QueueDepth];
  logic [VlWidth-1:0]   vl_q   [QueueDepth];
  vstu_pkg::ew_e        ew_q   [QueueDepth];

  // One pointer per phase
  logic [PtrWidth-1:0] accept_pnt_q, issue_pnt_q, commit_pnt_q;
  // Entries waiting for issue and for commit
  logic [CntWidth-1:0] issue_cnt_q, commit_cnt_q;
  // Ids still in flight
  logic [NumIds-1:0]   running_q;
  logic                accept;

  // Refuse when full or when the id is still running
  assign req_ready_o = (commit_cnt_q != CntWidth'(QueueDepth)) && !running_q[req_id_i];
  assign accept      = req_valid_i && req_ready_o;

  assign issue_valid_o   = (issue_cnt_q != '0);
  assign issue_addr_o    = addr_q[issue_pnt_q];
  assign issue_vl_o      = vl_q[issue_pnt_q];
  assign issue_ew_o      = ew_q[issue_pnt_q];
  assign store_pending_o = (commit_cnt_q != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      running_q    <= '0;
      done_valid_o <= 1'b0;
    end else begin
      issue_cnt_q  <= issue_cnt_q + CntWidth'(accept) - CntWidth'(issue_done_i);
      commit_cnt_q <= commit_cnt_q + CntWidth'(accept) - CntWidth'(commit_i);
      done_valid_o <= commit_i;
      // Wrap each pointer at the queue depth
      if (accept) begin
        accept_pnt_q <= (accept_pnt_q == PtrWidth'(QueueDepth - 1)) ? '0 : accept_pnt_q + 1'b1;
      end
      if (issue_done_i) begin
        issue_pnt_q <= (issue_pnt_q == PtrWidth'(QueueDepth - 1)) ? '0 : issue_pnt_q + 1'b1;
      end
      if (commit_i) begin
        commit_pnt_q <= (commit_pnt_q == PtrWidth'(QueueDepth - 1)) ? '0 : commit_pnt_q + 1'b1;
        running_q[id_q[commit_pnt_q]] <= 1'b0;
      end
      // Accepted id cannot be the committing one, it was still running
      if (accept) begin
        running_q[req_id_i] <= 1'b1;
      end
    end
  end

  // Payload store and completion id
  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_q[accept_pnt_q]   <= req_id_i;
      addr_q[accept_pnt_q] <= req_addr_i;
      vl_q[accept_pnt_q]   <= req_vl_i;
      ew_q[accept_pnt_q]   <= req_ew_i;
    end
    if (commit_i) begin
      done_id_o <= id_q[commit_pnt_q];
    end
  end

  // Beat generator only finishes an entry that is issuing
  assert property (@(posedge clk_i) disable iff (!rst_ni) issue_done_i |-> issue_valid_o);
  // Master only commits an instruction that is still queued
  assert property (@(posedge clk_i) disable iff (!rst_ni) commit_i |-> store_pending_o);

endmodule

// ==== store/store_beat_gen.sv ====
// Beat generator that cuts the issuing store into one descriptor per bus word
`timescale 1ns/1ps

module store_beat_gen #(
  parameter int unsigned NrLanes   = 2,
  parameter int unsigned VlWidth   = 8,
  parameter int unsigned AddrWidth = 16,
  parameter int          LaneWidth = (NrLanes > 1) ? $clog2(NrLanes) : 1
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Issuing instruction from the queue
  input  logic                          issue_valid_i,
  input  logic [AddrWidth-1:0]          issue_addr_i,
  input  logic [VlWidth-1:0]            issue_vl_i,
  input  vstu_pkg::ew_e                 issue_ew_i,
  output logic                          issue_done_o,
  // Beat descriptor to the master
  output logic                          beat_valid_o,
  input  logic                          beat_ready_i,
  output logic [AddrWidth-1:0]          beat_adr_o,
  output logic [vstu_pkg::BusBytes-1:0] beat_sel_o,
  output logic [LaneWidth-1:0]          beat_lane_o,
  output logic                          beat_last_word_o,
  output logic                          beat_last_insn_o
);

  // vl << 2 at most
  localparam int ByteCntWidth = VlWidth + 2;

  logic                    busy_q;
  logic [ByteCntWidth-1:0] rem_q;
  logic [LaneWidth-1:0]    lane_q;
  logic [AddrWidth-1:0]    adr_q;
  logic [31:0]             insn_len;
  logic [vstu_pkg::BusBytes-1:0] tail_sel;
  logic                    final_beat;
  logic                    beat_hs;

  assign insn_len = vstu_pkg::insn_bytes(32'(issue_vl_i), issue_ew_i);

  // Final beat holds the last BusBytes bytes or fewer
  assign final_beat = (rem_q <= ByteCntWidth'(vstu_pkg::BusBytes));
  assign beat_hs    = beat_valid_o && beat_ready_i;

  // Partial tail starts at byte 0, zero remainder is a full word
  always_comb begin
    tail_sel = '1;
    if (rem_q[1:0] != 2'd0) begin
      tail_sel = ~({vstu_pkg::BusBytes{1'b1}} << rem_q[1:0]);
    end
  end

  assign beat_valid_o     = busy_q;
  assign beat_adr_o       = adr_q;
  assign beat_sel_o       = final_beat ? tail_sel : '1;
  assign beat_lane_o      = lane_q;
  assign beat_last_word_o = final_beat || (lane_q == LaneWidth'(NrLanes - 1));
  assign beat_last_insn_o = final_beat;
  assign issue_done_o     = beat_hs && final_beat;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      rem_q  <= '0;
      lane_q <= '0;
    end else if (!busy_q) begin
      // Load the next instruction, each one starts on a fresh lane word
      if (issue_valid_i) begin
        busy_q <= 1'b1;
        rem_q  <= insn_len[ByteCntWidth-1:0];
        lane_q <= '0;
      end
    end else if (beat_hs) begin
      busy_q <= !final_beat;
      rem_q  <= rem_q - ByteCntWidth'(vstu_pkg::BusBytes);
      lane_q <= beat_last_word_o ? '0 : lane_q + 1'b1;
    end
  end

  // Address walks one bus word per beat
  always_ff @(posedge clk_i) begin
    if (!busy_q && issue_valid_i) begin
      adr_q <= issue_addr_i;
    end else if (beat_hs) begin
      adr_q <= adr_q + AddrWidth'(vstu_pkg::BusBytes);
    end
  end

  // Descriptor held until the master takes it
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    beat_valid_o && !beat_ready_i |=> beat_valid_o && $stable(beat_adr_o) &&
      $stable(beat_sel_o) && $stable(beat_lane_o) && $stable(beat_last_insn_o));

endmodule

// ==== store/lane_word_buffer.sv ====
// Two-entry FIFO of full lane words between the lanes and the Wishbone master
`timescale 1ns/1ps

module lane_word_buffer #(
  parameter int unsigned NrLanes   = 2,
  parameter int          DataWidth = NrLanes * vstu_pkg::BusBytes * 8
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Lane side
  input  logic                 lane_valid_i,
  output logic                 lane_ready_o,
  input  logic [DataWidth-1:0] lane_data_i,
  // Master side
  output logic                 word_valid_o,
  output logic [DataWidth-1:0] word_data_o,
  input  logic                 word_pop_i
);

  logic [DataWidth-1:0] mem_q [2];
  logic                 wr_ptr_q, rd_ptr_q;
  logic [1:0]           cnt_q;
  logic                 push;

  // Lanes may run one word ahead of the bus
  assign lane_ready_o = (cnt_q != 2'd2);
  assign push         = lane_valid_i && lane_ready_o;
  assign word_valid_o = (cnt_q != 2'd0);
  assign word_data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      cnt_q    <= 2'd0;
    end else begin
      if (push) wr_ptr_q <= !wr_ptr_q;
      if (word_pop_i) rd_ptr_q <= !rd_ptr_q;
      cnt_q <= cnt_q + 2'(push) - 2'(word_pop_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= lane_data_i;
    end
  end

  // Master pops only a word it was handed
  assert property (@(posedge clk_i) disable iff (!rst_ni) word_pop_i |-> word_valid_o);

endmodule

// ==== store/wb_store_master.sv ====
// Wishbone classic write master that joins beat descriptors with buffered lane words
`timescale 1ns/1ps

module wb_store_master #(
  parameter int unsigned NrLanes   = 2,
  parameter int unsigned AddrWidth = 16,
  parameter int          LaneWidth = (NrLanes > 1) ? $clog2(NrLanes) : 1
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // Beat descriptor
  input  logic                                  beat_valid_i,
  output logic                                  beat_ready_o,
  input  logic [AddrWidth-1:0]                  beat_adr_i,
  input  logic [vstu_pkg::BusBytes-1:0]         beat_sel_i,
  input  logic [LaneWidth-1:0]                  beat_lane_i,
  input  logic                                  beat_last_word_i,
  input  logic                                  beat_last_insn_i,
  // Head lane word
  input  logic                                  word_valid_i,
  input  logic [NrLanes*vstu_pkg::WordWidth-1:0] word_data_i,
  output logic                                  word_pop_o,
  // Last ack of an instruction
  output logic                                  commit_o,
  // Wishbone classic
  output logic                                  wb_cyc_o,
  output logic                                  wb_stb_o,
  output logic                                  wb_we_o,
  output logic [AddrWidth-1:0]                  wb_adr_o,
  output logic [vstu_pkg::WordWidth-1:0]        wb_dat_o,
  output logic [vstu_pkg::BusBytes-1:0]         wb_sel_o,
  input  logic                                  wb_ack_i
);

  logic                           busy_q;
  logic                           last_word_q;
  logic                           last_insn_q;
  logic [vstu_pkg::WordWidth-1:0] lane_slice;
  logic                           take;
  logic                           done;

  // Lane k of the head word feeds this beat
  assign lane_slice = word_data_i[beat_lane_i*vstu_pkg::WordWidth +: vstu_pkg::WordWidth];

  // Idle and a head word present
  assign beat_ready_o = !busy_q && word_valid_i;
  assign take         = beat_ready_o && beat_valid_i;
  assign done         = busy_q && wb_ack_i;

  assign wb_cyc_o = busy_q;
  assign wb_stb_o = busy_q;
  assign wb_we_o  = busy_q;

  // Word leaves the buffer after its last beat is acked
  assign word_pop_o = done && last_word_q;
  assign commit_o   = done && last_insn_q;

  // cyc and stb rise the edge after take, drop the edge after ack
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else if (take) begin
      busy_q <= 1'b1;
    end else if (done) begin
      busy_q <= 1'b0;
    end
  end

  // Bus payload latched once per beat
  always_ff @(posedge clk_i) begin
    if (take) begin
      wb_adr_o    <= beat_adr_i;
      wb_dat_o    <= lane_slice;
      wb_sel_o    <= beat_sel_i;
      last_word_q <= beat_last_word_i;
      last_insn_q <= beat_last_insn_i;
    end
  end

  // Bus fields hold until the slave acks
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o) && $stable(wb_dat_o) &&
      $stable(wb_sel_o));

endmodule

// ==== src/vstu_top.sv ====
// Vector store unit top that links queue, beat generator, lane buffer and Wishbone master
`timescale 1ns/1ps

module vstu_top #(
  parameter int unsigned NrLanes    = 2,
  parameter int unsigned QueueDepth = 4,
  parameter int unsigned IdWidth    = 3,
  parameter int unsigned VlWidth    = 8,
  parameter int unsigned AddrWidth  = 16
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  // Sequencer requests
  input  logic                                   req_valid_i,
  output logic                                   req_ready_o,
  input  logic [IdWidth-1:0]                     req_id_i,
  input  logic [AddrWidth-1:0]                   req_addr_i,
  input  logic [VlWidth-1:0]                     req_vl_i,
  input  vstu_pkg::ew_e                          req_ew_i,
  // Lane operands
  input  logic                                   lane_valid_i,
  input  logic [NrLanes*vstu_pkg::WordWidth-1:0] lane_data_i,
  output logic                                   lane_ready_o,
  // Wishbone classic
  output logic                                   wb_cyc_o,
  output logic                                   wb_stb_o,
  output logic                                   wb_we_o,
  output logic [AddrWidth-1:0]                   wb_adr_o,
  output logic [vstu_pkg::WordWidth-1:0]         wb_dat_o,
  output logic [vstu_pkg::BusBytes-1:0]          wb_sel_o,
  input  logic                                   wb_ack_i,
  // Completion
  output logic                                   done_valid_o,
  output logic [IdWidth-1:0]                     done_id_o,
  output logic                                   store_pending_o
);

  localparam int LaneWidth = (NrLanes > 1) ? $clog2(NrLanes) : 1;

  // Queue to beat generator
  logic                 issue_valid, issue_done;
  logic [AddrWidth-1:0] issue_addr;
  logic [VlWidth-1:0]   issue_vl;
  vstu_pkg::ew_e        issue_ew;

  // Beat generator to master
  logic                          beat_valid, beat_ready;
  logic [AddrWidth-1:0]          beat_adr;
  logic [vstu_pkg::BusBytes-1:0] beat_sel;
  logic [LaneWidth-1:0]          beat_lane;
  logic                          beat_last_word, beat_last_insn;

  // Buffer to master, and commit back to the queue
  logic                                   word_valid, word_pop, commit;
  logic [NrLanes*vstu_pkg::WordWidth-1:0] word_data;

  vinsn_queue #(
    .QueueDepth(QueueDepth), .IdWidth(IdWidth), .VlWidth(VlWidth), .AddrWidth(AddrWidth)
  ) u_queue (
    .clk_i, .rst_ni, .req_valid_i, .req_ready_o, .req_id_i, .req_addr_i, .req_vl_i,
    .req_ew_i, .issue_valid_o(issue_valid), .issue_addr_o(issue_addr),
    .issue_vl_o(issue_vl), .issue_ew_o(issue_ew), .issue_done_i(issue_done),
    .commit_i(commit), .done_valid_o, .done_id_o, .store_pending_o
  );

  store_beat_gen #(
    .NrLanes(NrLanes), .VlWidth(VlWidth), .AddrWidth(AddrWidth), .LaneWidth(LaneWidth)
  ) u_beat_gen (
    .clk_i, .rst_ni, .issue_valid_i(issue_valid), .issue_addr_i(issue_addr),
    .issue_vl_i(issue_vl), .issue_ew_i(issue_ew), .issue_done_o(issue_done),
    .beat_valid_o(beat_valid), .beat_ready_i(beat_ready), .beat_adr_o(beat_adr),
    .beat_sel_o(beat_sel), .beat_lane_o(beat_lane), .beat_last_word_o(beat_last_word),
    .beat_last_insn_o(beat_last_insn)
  );

  lane_word_buffer #(
    .NrLanes(NrLanes), .DataWidth(NrLanes * vstu_pkg::WordWidth)
  ) u_buffer (
    .clk_i, .rst_ni, .lane_valid_i, .lane_ready_o, .lane_data_i,
    .word_valid_o(word_valid), .word_data_o(word_data), .word_pop_i(word_pop)
  );

  wb_store_master #(
    .NrLanes(NrLanes), .AddrWidth(AddrWidth), .LaneWidth(LaneWidth)
  ) u_master (
    .clk_i, .rst_ni, .beat_valid_i(beat_valid), .beat_ready_o(beat_ready),
    .beat_adr_i(beat_adr), .beat_sel_i(beat_sel), .beat_lane_i(beat_lane),
    .beat_last_word_i(beat_last_word), .beat_last_insn_i(beat_last_insn),
    .word_valid_i(word_valid), .word_data_i(word_data), .word_pop_o(word_pop),
    .commit_o(commit), .wb_cyc_o, .wb_stb_o, .wb_we_o, .wb_adr_o, .wb_dat_o, .wb_sel_o,
    .wb_ack_i
  );

endmodule

// ==== tests/wb_mem_model.sv ====
// Wishbone slave memory with random ack delay that records the written bytes
`timescale 1ns/1ps

module wb_mem_model #(
  parameter int unsigned AddrWidth = 16
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Holds off ack while high
  input  logic                          hold_i,
  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_we_i,
  input  logic [AddrWidth-1:0]          wb_adr_i,
  input  logic [vstu_pkg::WordWidth-1:0] wb_dat_i,
  input  logic [vstu_pkg::BusBytes-1:0] wb_sel_i,
  output logic                          wb_ack_o
);

  logic [7:0]  mem_q [2**AddrWidth];
  int unsigned wait_q;

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_ack_o <= 1'b0;
      wait_q   <= 0;
    end else if (wb_ack_o) begin
      // One ack per write, then a fresh delay of 0 to 3 cycles
      wb_ack_o <= 1'b0;
      wait_q   <= $urandom_range(3, 0);
    end else if (wb_cyc_i && wb_stb_i && !hold_i) begin
      if (wait_q == 0) begin
        wb_ack_o <= 1'b1;
        // Keep only the enabled bytes
        for (int j = 0; j < vstu_pkg::BusBytes; j++) begin
          if (wb_we_i && wb_sel_i[j]) begin
            mem_q[AddrWidth'(wb_adr_i + j)] <= wb_dat_i[8*j +: 8];
          end
        end
      end else begin
        wait_q <= wait_q - 1;
      end
    end
  end

endmodule

// ==== tests/tb_vstu.sv ====
// Testbench for the vector store unit with pattern lane data, a Wishbone memory and checks
`timescale 1ns/1ps

module tb_vstu;

  localparam int unsigned NrLanes    = 2;
  localparam int unsigned QueueDepth = 4;
  localparam int unsigned IdWidth    = 3;
  localparam int unsigned VlWidth    = 8;
  localparam int unsigned AddrWidth  = 16;
  localparam int          WordBytes  = NrLanes * vstu_pkg::BusBytes;
  localparam int          NumTests   = 6;
  localparam int          ClkPeriod  = 20;

  logic                                   clk_i = 1'b0;
  logic                                   rst_ni;
  logic                                   req_valid_i;
  logic                                   req_ready_o;
  logic [IdWidth-1:0]                     req_id_i;
  logic [AddrWidth-1:0]                   req_addr_i;
  logic [VlWidth-1:0]                     req_vl_i;
  vstu_pkg::ew_e                          req_ew_i;
  logic                                   lane_valid_i;
  logic [NrLanes*vstu_pkg::WordWidth-1:0] lane_data_i;
  logic                                   lane_ready_o;
  logic                                   wb_cyc_o;
  logic                                   wb_stb_o;
  logic                                   wb_we_o;
  logic [AddrWidth-1:0]                   wb_adr_o;
  logic [vstu_pkg::WordWidth-1:0]         wb_dat_o;
  logic [vstu_pkg::BusBytes-1:0]          wb_sel_o;
  logic                                   wb_ack_i;
  logic                                   done_valid_o;
  logic [IdWidth-1:0]                     done_id_o;
  logic                                   store_pending_o;
  logic                                   hold;

  // Reference state
  int errors       = 0;
  int tests_run    = 0;
  int tests_failed = 0;
  int test_errs    = 0;
  int lane_pushes  = 0;
  int beat_n       = 0;
  int acc_len;
  int done_q [$];
  int bus_id_q [$];
  int bus_adr_q [$];
  int bus_len_q [$];
  logic [NrLanes*vstu_pkg::WordWidth-1:0] lane_q [$];
  logic [NrLanes*vstu_pkg::WordWidth-1:0] acc_word;

  vstu_top #(
    .NrLanes(NrLanes), .QueueDepth(QueueDepth), .IdWidth(IdWidth), .VlWidth(VlWidth),
    .AddrWidth(AddrWidth)
  ) u_dut (.*);

  wb_mem_model #(.AddrWidth(AddrWidth)) u_mem (
    .clk_i, .rst_ni, .hold_i(hold), .wb_cyc_i(wb_cyc_o), .wb_stb_i(wb_stb_o),
    .wb_we_i(wb_we_o), .wb_adr_i(wb_adr_o), .wb_dat_i(wb_dat_o), .wb_sel_i(wb_sel_o),
    .wb_ack_o(wb_ack_i)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  // Stream byte b of instruction id
  function automatic logic [7:0] pattern_byte(input int id, input int b);
    return 8'((id * 16 + b) % 256);
  endfunction

  // Full word except a partial final beat
  function automatic logic [3:0] expect_sel(input int len, input int n);
    if (n != (len + 3) / 4 - 1 || len % 4 == 0) begin
      return 4'hf;
    end
    return 4'((1 << (len % 4)) - 1);
  endfunction

  task automatic report_mismatch(input string sig, input longint exp, input longint act);
    errors++;
    $display("** Error @ %0t: %s expected %0h actual %0h", $time, sig, exp, act);
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("Error @ %0t: %s", $time, what);
  endtask

  // Holds the request until the edge where it is taken
  task automatic send_req(input int id, input int adr, input int vl, input vstu_pkg::ew_e ew);
    req_valid_i = 1'b1;
    req_id_i    = IdWidth'(id);
    req_addr_i  = AddrWidth'(adr);
    req_vl_i    = VlWidth'(vl);
    req_ew_i    = ew;
    do begin
      @(posedge clk_i);
    end while (!req_ready_o);
    #2;
    req_valid_i = 1'b0;
  endtask

  task automatic wait_idle();
    do begin
      @(negedge clk_i);
    end while (done_q.size() != 0);
    @(posedge clk_i);
    #2;
  endtask

  // Stored bytes of a finished instruction as the memory model recorded them
  task automatic check_memory(input int id, input int adr, input int len);
    logic [7:0] mem_byte;
    for (int b = 0; b < len; b++) begin
      mem_byte = u_mem.mem_q[AddrWidth'(adr + b)];
      assert (mem_byte === pattern_byte(id, b))
        else report_mismatch($sformatf("memory byte %0h", AddrWidth'(adr + b)),
          pattern_byte(id, b), mem_byte);
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors != test_errs) begin
      tests_failed++;
    end
    $display("test %0d %s: %s", tests_run, name, (errors == test_errs) ? "ok" : "failed");
    test_errs = errors;
  endtask

  // Completion order, bus beats and lane words all follow acceptance order
  always @(posedge clk_i) begin
    if (rst_ni) begin
      assert (store_pending_o == (done_q.size() > int'(done_valid_o)))
        else report_mismatch("store_pending_o", !store_pending_o, store_pending_o);
      if (done_valid_o) begin
        if (done_q.size() == 0) begin
          report_failure("completion pulse with no request outstanding");
        end else begin
          assert (done_id_o == IdWidth'(done_q[0]))
            else report_mismatch("done_id_o", done_q[0], done_id_o);
          void'(done_q.pop_front());
        end
      end
      if (wb_stb_o && wb_ack_i) begin
        if (bus_id_q.size() == 0) begin
          report_failure("bus write with no request outstanding");
        end else begin
          assert (wb_adr_o == AddrWidth'(bus_adr_q[0] + 4 * beat_n))
            else report_mismatch("wb_adr_o", AddrWidth'(bus_adr_q[0] + 4 * beat_n), wb_adr_o);
          assert (wb_sel_o == expect_sel(bus_len_q[0], beat_n))
            else report_mismatch("wb_sel_o", expect_sel(bus_len_q[0], beat_n), wb_sel_o);
          for (int j = 0; j < 4; j++) begin
            if (expect_sel(bus_len_q[0], beat_n) & (1 << j)) begin
              assert (wb_dat_o[8*j +: 8] == pattern_byte(bus_id_q[0], 4 * beat_n + j))
                else report_mismatch($sformatf("wb_dat_o byte %0d", j),
                  pattern_byte(bus_id_q[0], 4 * beat_n + j), wb_dat_o[8*j +: 8]);
            end
          end
          beat_n++;
          if (beat_n == (bus_len_q[0] + 3) / 4) begin
            beat_n = 0;
            void'(bus_id_q.pop_front());
            void'(bus_adr_q.pop_front());
            void'(bus_len_q.pop_front());
          end
        end
      end
      if (req_valid_i && req_ready_o) begin
        acc_len = int'(req_vl_i) << req_ew_i;
        done_q.push_back(req_id_i);
        bus_id_q.push_back(req_id_i);
        bus_adr_q.push_back(req_addr_i);
        bus_len_q.push_back(acc_len);
        // Each instruction starts on a fresh lane word
        for (int w = 0; w < (acc_len + WordBytes - 1) / WordBytes; w++) begin
          for (int j = 0; j < WordBytes; j++) begin
            acc_word[8*j +: 8] = pattern_byte(req_id_i, w * WordBytes + j);
          end
          lane_q.push_back(acc_word);
        end
      end
    end
  end

  // Lane words go out in order, driven 2 ns after the edge
  always @(posedge clk_i) begin
    if (lane_valid_i && lane_ready_o) begin
      void'(lane_q.pop_front());
      lane_pushes++;
    end
    #2;
    lane_valid_i = (lane_q.size() != 0);
    lane_data_i  = (lane_q.size() != 0) ? lane_q[0] : '0;
  end

  // Request fields hold while the slave stalls
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o) && $stable(wb_dat_o) &&
      $stable(wb_sel_o))
    else report_failure("Wishbone request changed or dropped before ack");
  assert property (@(posedge clk_i) disable iff (!rst_ni) wb_stb_o |-> wb_cyc_o && wb_we_o)
    else report_failure("stb high without cyc and we");

  initial begin
    #(NumTests * 2000 * ClkPeriod);
    $display("Timeout: run did not end within %0d cycles", NumTests * 2000);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    int vl;
    int ew;
    int wait_cnt;
    int lane_start;
    void'($urandom(32'h9bbfce78));
    rst_ni       = 1'b0;
    req_valid_i  = 1'b0;
    req_id_i     = '0;
    req_addr_i   = '0;
    req_vl_i     = '0;
    req_ew_i     = vstu_pkg::EW8;
    lane_valid_i = 1'b0;
    lane_data_i  = '0;
    hold         = 1'b0;
    repeat (4) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    assert (!wb_cyc_o) else report_mismatch("wb_cyc_o", 0, wb_cyc_o);
    assert (!wb_stb_o) else report_mismatch("wb_stb_o", 0, wb_stb_o);
    assert (!done_valid_o) else report_mismatch("done_valid_o", 0, done_valid_o);
    assert (!store_pending_o) else report_mismatch("store_pending_o", 0, store_pending_o);
    assert (req_ready_o) else report_mismatch("req_ready_o", 1, req_ready_o);
    assert (lane_ready_o) else report_mismatch("lane_ready_o", 1, lane_ready_o);
    end_test("reset values");

    send_req(1, 'h1000, 20, vstu_pkg::EW8);
    wait_idle();
    send_req(2, 'h2000, 9, vstu_pkg::EW16);
    wait_idle();
    send_req(3, 'h3000, 7, vstu_pkg::EW32);
    wait_idle();
    check_memory(1, 'h1000, 20);
    check_memory(2, 'h2000, 18);
    check_memory(3, 'h3000, 28);
    end_test("element widths");

    // Byte lengths 5 to 8 cover every remainder modulo 4
    for (int k = 1; k <= 4; k++) begin
      send_req(k, 'h400 * k, 4 + k, vstu_pkg::EW8);
    end
    send_req(5, 'h2400, 3, vstu_pkg::EW16);
    wait_idle();
    end_test("partial last beat");

    // Back to back, ids recycle once they complete
    for (int k = 0; k < 12; k++) begin
      vl = $urandom_range(40, 1);
      ew = $urandom_range(2, 0);
      send_req(k % 8, $urandom & 'hfffc, vl, vstu_pkg::ew_e'(ew));
    end
    wait_idle();
    end_test("in-order completion");

    // Bus held, so nothing completes while the queue fills
    hold = 1'b1;
    send_req(0, 'h0100, 4, vstu_pkg::EW32);
    req_valid_i = 1'b1;
    repeat (3) begin
      @(posedge clk_i);
      assert (!req_ready_o) else report_mismatch("req_ready_o", 0, req_ready_o);
    end
    #2;
    req_valid_i = 1'b0;
    for (int k = 1; k < QueueDepth; k++) begin
      send_req(k, 'h0100 + 'h100 * k, 4, vstu_pkg::EW32);
    end
    req_id_i = IdWidth'(QueueDepth + 1);
    @(posedge clk_i);
    assert (!req_ready_o) else report_mismatch("req_ready_o", 0, req_ready_o);
    #2;
    hold = 1'b0;
    wait_idle();
    end_test("queue back-pressure");

    // Long store against a stalled bus
    hold       = 1'b1;
    lane_start = lane_pushes;
    send_req(6, 'h8000, 32, vstu_pkg::EW32);
    wait_cnt = 0;
    while (lane_ready_o && wait_cnt < 20) begin
      @(posedge clk_i);
      wait_cnt++;
    end
    #2;
    if (wait_cnt == 20) begin
      report_failure("lane_ready_o stayed high with the bus stalled");
    end
    assert (lane_pushes - lane_start == 2)
      else report_mismatch("lane words buffered", 2, lane_pushes - lane_start);
    assert (wb_stb_o) else report_mismatch("wb_stb_o", 1, wb_stb_o);
    repeat (5) @(posedge clk_i);
    #2;
    hold = 1'b0;
    wait_idle();
    end_test("bus stall");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
common/vstu_pkg.sv
store/vinsn_queue.sv
store/store_beat_gen.sv
store/lane_word_buffer.sv
store/wb_store_master.sv
src/vstu_top.sv
tests/wb_mem_model.sv
tests/tb_vstu.sv
